//--- src/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

`define CSR_XLEN 32

// RV32IMAC. MXL = 1 plus extension bits A, C, I and M.
`define CSR_MISA_VAL 32'h4000_1105

// Bit positions inside mstatus.
`define CSR_MSTATUS_MIE_BIT  3
`define CSR_MSTATUS_MPIE_BIT 7

// Bit positions inside mie and mip match the interrupt codes.
`define CSR_IRQ_MSI_BIT 3
`define CSR_IRQ_MEI_BIT 11

`define CSR_ADDR_MSTATUS   12'h300
`define CSR_ADDR_MISA      12'h301
`define CSR_ADDR_MIE       12'h304
`define CSR_ADDR_MTVEC     12'h305
`define CSR_ADDR_MSCRATCH  12'h340
`define CSR_ADDR_MEPC      12'h341
`define CSR_ADDR_MCAUSE    12'h342
`define CSR_ADDR_MIP       12'h344
`define CSR_ADDR_MCYCLE    12'hB00
`define CSR_ADDR_MINSTRET  12'hB02
`define CSR_ADDR_MCYCLEH   12'hB80
`define CSR_ADDR_MINSTRETH 12'hB82
`define CSR_ADDR_CYCLE     12'hC00
`define CSR_ADDR_INSTRET   12'hC02
`define CSR_ADDR_CYCLEH    12'hC80
`define CSR_ADDR_INSTRETH  12'hC82

`endif

//--- src/csr_pkg.sv
package csr_pkg;

    // Same encoding as funct3 of the SYSTEM opcode.
    // Bit 2 set means the 5-bit immediate is the source.
    typedef enum logic [2:0] {
        CSR_NONE = 3'b000,
        CSR_RW   = 3'b001,
        CSR_RS   = 3'b010,
        CSR_RC   = 3'b011,
        CSR_RWI  = 3'b101,
        CSR_RSI  = 3'b110,
        CSR_RCI  = 3'b111
    } csr_op_e;

    // Debug port handshake.
    typedef enum logic {
        ARB_IDLE = 1'b0, // Waiting for a strobe.
        ARB_ACK  = 1'b1  // Ack with read data.
    } arb_state_e;

endpackage

//--- src/csr_file.sv
`include "csr_cfg.svh"

module csr_file (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 acc_valid_i,
    input  csr_pkg::csr_op_e     acc_op_i,
    input  logic [11:0]          acc_addr_i,
    input  logic [`CSR_XLEN-1:0] acc_src_i,
    output logic [`CSR_XLEN-1:0] acc_rdata_o,
    input  logic                 instr_retired_i,
    input  logic                 ext_irq_i,
    input  logic                 sw_irq_i,
    input  logic                 trap_enter_i,
    input  logic [`CSR_XLEN-1:0] trap_cause_i,
    input  logic [`CSR_XLEN-1:0] trap_epc_i,
    input  logic                 mret_exec_i,
    output logic                 mstatus_mie_o,
    output logic [`CSR_XLEN-1:0] mie_o,
    output logic [`CSR_XLEN-1:0] mtvec_o,
    output logic [`CSR_XLEN-1:0] mepc_o
);
    import csr_pkg::*;

    logic                 mstatus_mie_q;
    logic                 mstatus_mpie_q;
    logic [`CSR_XLEN-1:0] mie_q;
    logic [`CSR_XLEN-1:0] mtvec_q;
    logic [`CSR_XLEN-1:0] mscratch_q;
    logic [`CSR_XLEN-1:0] mepc_q;
    logic [`CSR_XLEN-1:0] mcause_q;
    logic [63:0]          mcycle_q;
    logic [63:0]          minstret_q;
    logic [`CSR_XLEN-1:0] mstatus_rd;
    logic [`CSR_XLEN-1:0] mip_rd;
    logic [`CSR_XLEN-1:0] rdata;
    logic [`CSR_XLEN-1:0] wdata;
    logic                 wr_en;

    // Only MIE and MPIE exist in mstatus. MIP follows the lines live.
    always_comb begin
        mstatus_rd = '0;
        mstatus_rd[`CSR_MSTATUS_MIE_BIT]  = mstatus_mie_q;
        mstatus_rd[`CSR_MSTATUS_MPIE_BIT] = mstatus_mpie_q;
        mip_rd = '0;
        mip_rd[`CSR_IRQ_MEI_BIT] = ext_irq_i;
        mip_rd[`CSR_IRQ_MSI_BIT] = sw_irq_i;
    end

    always_comb begin
        case (acc_addr_i)
            `CSR_ADDR_MSTATUS:   rdata = mstatus_rd;
            `CSR_ADDR_MISA:      rdata = `CSR_MISA_VAL;
            `CSR_ADDR_MIE:       rdata = mie_q;
            `CSR_ADDR_MTVEC:     rdata = mtvec_q;
            `CSR_ADDR_MSCRATCH:  rdata = mscratch_q;
            `CSR_ADDR_MEPC:      rdata = mepc_q;
            `CSR_ADDR_MCAUSE:    rdata = mcause_q;
            `CSR_ADDR_MIP:       rdata = mip_rd;
            `CSR_ADDR_MCYCLE,
            `CSR_ADDR_CYCLE:     rdata = mcycle_q[31:0];
            `CSR_ADDR_MCYCLEH,
            `CSR_ADDR_CYCLEH:    rdata = mcycle_q[63:32];
            `CSR_ADDR_MINSTRET,
            `CSR_ADDR_INSTRET:   rdata = minstret_q[31:0];
            `CSR_ADDR_MINSTRETH,
            `CSR_ADDR_INSTRETH:  rdata = minstret_q[63:32];
            default:             rdata = '0; // Unknown address.
        endcase
    end

    assign acc_rdata_o = rdata;

    // Read-modify-write from the old value.
    always_comb begin
        unique case (acc_op_i)
            CSR_RW, CSR_RWI: wdata = acc_src_i;
            CSR_RS, CSR_RSI: wdata = rdata | acc_src_i;
            CSR_RC, CSR_RCI: wdata = rdata & ~acc_src_i;
            default:         wdata = rdata;
        endcase
    end

    assign wr_en = acc_valid_i && (acc_op_i != CSR_NONE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
            mie_q          <= '0;
            mtvec_q        <= '0;
            mscratch_q     <= '0;
            mepc_q         <= '0;
            mcause_q       <= '0;
        end else begin
            if (wr_en) begin
                case (acc_addr_i)
                    `CSR_ADDR_MSTATUS: begin
                        mstatus_mie_q  <= wdata[`CSR_MSTATUS_MIE_BIT];
                        mstatus_mpie_q <= wdata[`CSR_MSTATUS_MPIE_BIT];
                    end
                    `CSR_ADDR_MIE:      mie_q      <= wdata;
                    `CSR_ADDR_MTVEC:    mtvec_q    <= wdata;
                    `CSR_ADDR_MSCRATCH: mscratch_q <= wdata;
                    `CSR_ADDR_MEPC:     mepc_q     <= wdata;
                    `CSR_ADDR_MCAUSE:   mcause_q   <= wdata;
                    default:            ; // Read-only or unknown addresses are dropped.
                endcase
            end
            // Trap side effects come last so they win.
            if (trap_enter_i) begin
                mepc_q         <= trap_epc_i;
                mcause_q       <= trap_cause_i;
                mstatus_mpie_q <= mstatus_mie_q;
                mstatus_mie_q  <= 1'b0;
            end else if (mret_exec_i) begin
                mstatus_mie_q  <= mstatus_mpie_q;
                mstatus_mpie_q <= 1'b1;
            end
        end
    end

    // Counters. A write to one half replaces that half for the cycle.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            mcycle_q <= mcycle_q + 64'd1;
            if (instr_retired_i) begin
                minstret_q <= minstret_q + 64'd1;
            end
            if (wr_en) begin
                case (acc_addr_i)
                    `CSR_ADDR_MCYCLE:    mcycle_q[31:0]    <= wdata;
                    `CSR_ADDR_MCYCLEH:   mcycle_q[63:32]   <= wdata;
                    `CSR_ADDR_MINSTRET:  minstret_q[31:0]  <= wdata;
                    `CSR_ADDR_MINSTRETH: minstret_q[63:32] <= wdata;
                    default:             ;
                endcase
            end
        end
    end

    assign mstatus_mie_o = mstatus_mie_q;
    assign mie_o         = mie_q;
    assign mtvec_o       = mtvec_q;
    assign mepc_o        = mepc_q;

endmodule

//--- src/csr_port_arb.sv
`include "csr_cfg.svh"

module csr_port_arb (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 csr_req_i,
    input  csr_pkg::csr_op_e     csr_op_i,
    input  logic [11:0]          csr_addr_i,
    input  logic [`CSR_XLEN-1:0] csr_wdata_i,
    input  logic [4:0]           csr_imm_i,
    output logic [`CSR_XLEN-1:0] csr_rdata_o,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  logic [11:0]          wb_adr_i,
    input  logic [`CSR_XLEN-1:0] wb_dat_i,
    output logic [`CSR_XLEN-1:0] wb_dat_o,
    output logic                 wb_ack_o,
    output logic                 acc_valid_o,
    output csr_pkg::csr_op_e     acc_op_o,
    output logic [11:0]          acc_addr_o,
    output logic [`CSR_XLEN-1:0] acc_src_o,
    input  logic [`CSR_XLEN-1:0] acc_rdata_i
);
    import csr_pkg::*;

    arb_state_e state_q;
    arb_state_e state_d;
    logic       dbg_grant;

    // Debug only gets the port in a cycle the core leaves free.
    assign dbg_grant = wb_cyc_i && wb_stb_i && !csr_req_i && (state_q == ARB_IDLE);

    always_comb begin
        acc_valid_o = csr_req_i || dbg_grant;
        if (csr_req_i) begin
            acc_op_o   = csr_op_i;
            acc_addr_o = csr_addr_i;
            // Immediate forms zero-extend the 5-bit field.
            acc_src_o  = csr_op_i[2] ? {{(`CSR_XLEN-5){1'b0}}, csr_imm_i} : csr_wdata_i;
        end else begin
            if (wb_we_i) begin
                acc_op_o = CSR_RW;
            end else begin
                acc_op_o = CSR_NONE;
            end
            acc_addr_o = wb_adr_i;
            acc_src_o  = wb_dat_i;
        end
    end

    assign csr_rdata_o = acc_rdata_i; // Old value in the same cycle.

    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: if (dbg_grant) state_d = ARB_ACK;
            ARB_ACK:  state_d = ARB_IDLE; // Master drops stb or restarts.
            default:  state_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (dbg_grant) begin
            wb_dat_o <= acc_rdata_i;
        end
    end

    assign wb_ack_o = (state_q == ARB_ACK);

endmodule

//--- src/csr_trap_ctrl.sv
`include "csr_cfg.svh"

module csr_trap_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ext_irq_i,
    input  logic                 sw_irq_i,
    input  logic                 mret_i,
    input  logic [`CSR_XLEN-1:0] resume_pc_i,
    input  logic                 mstatus_mie_i,
    input  logic [`CSR_XLEN-1:0] mie_i,
    input  logic [`CSR_XLEN-1:0] mtvec_i,
    input  logic [`CSR_XLEN-1:0] mepc_i,
    output logic                 trap_enter_o,
    output logic [`CSR_XLEN-1:0] trap_cause_o,
    output logic [`CSR_XLEN-1:0] trap_epc_o,
    output logic                 mret_exec_o,
    output logic                 trap_flush_o,
    output logic [`CSR_XLEN-1:0] trap_pc_o
);

    logic                 ext_pend;
    logic                 sw_pend;
    logic [4:0]           irq_code;
    logic [`CSR_XLEN-1:0] tvec_base;
    logic [`CSR_XLEN-1:0] trap_target;

    assign ext_pend = ext_irq_i && mie_i[`CSR_IRQ_MEI_BIT];
    assign sw_pend  = sw_irq_i && mie_i[`CSR_IRQ_MSI_BIT];

    // External wins over software.
    assign irq_code = ext_pend ? 5'(`CSR_IRQ_MEI_BIT) : 5'(`CSR_IRQ_MSI_BIT);

    // No new trap while the pipeline is being flushed or MRET retires.
    assign trap_enter_o = mstatus_mie_i && (ext_pend || sw_pend) && !trap_flush_o && !mret_i;

    assign trap_cause_o = {1'b1, {(`CSR_XLEN-6){1'b0}}, irq_code}; // Interrupt flag set.
    assign trap_epc_o   = resume_pc_i;
    assign mret_exec_o  = mret_i;

    assign tvec_base = {mtvec_i[`CSR_XLEN-1:2], 2'b00};

    // Vectored mode jumps to base plus four times the code.
    always_comb begin
        if (mtvec_i[0]) begin
            trap_target = tvec_base + {{(`CSR_XLEN-7){1'b0}}, irq_code, 2'b00};
        end else begin
            trap_target = tvec_base;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            trap_flush_o <= 1'b0;
            trap_pc_o    <= '0;
        end else begin
            trap_flush_o <= trap_enter_o || mret_i; // One cycle pulse.
            if (trap_enter_o) begin
                trap_pc_o <= trap_target;
            end else if (mret_i) begin
                trap_pc_o <= mepc_i;
            end
        end
    end

endmodule

//--- src/csr_subsystem.sv
`include "csr_cfg.svh"

module csr_subsystem (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 csr_req_i,
    input  csr_pkg::csr_op_e     csr_op_i,
    input  logic [11:0]          csr_addr_i,
    input  logic [`CSR_XLEN-1:0] csr_wdata_i,
    input  logic [4:0]           csr_imm_i,
    output logic [`CSR_XLEN-1:0] csr_rdata_o,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  logic [11:0]          wb_adr_i,
    input  logic [`CSR_XLEN-1:0] wb_dat_i,
    output logic [`CSR_XLEN-1:0] wb_dat_o,
    output logic                 wb_ack_o,
    input  logic                 ext_irq_i,
    input  logic                 sw_irq_i,
    input  logic                 instr_retired_i,
    input  logic [`CSR_XLEN-1:0] resume_pc_i,
    input  logic                 mret_i,
    output logic                 trap_flush_o,
    output logic [`CSR_XLEN-1:0] trap_pc_o
);
    import csr_pkg::*;

    logic                 acc_valid;
    csr_op_e              acc_op;
    logic [11:0]          acc_addr;
    logic [`CSR_XLEN-1:0] acc_src;
    logic [`CSR_XLEN-1:0] acc_rdata;
    logic                 trap_enter;
    logic [`CSR_XLEN-1:0] trap_cause;
    logic [`CSR_XLEN-1:0] trap_epc;
    logic                 mret_exec;
    logic                 mstatus_mie;
    logic [`CSR_XLEN-1:0] mie_q;
    logic [`CSR_XLEN-1:0] mtvec_q;
    logic [`CSR_XLEN-1:0] mepc_q;

    csr_port_arb u_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_req_i   (csr_req_i),
        .csr_op_i    (csr_op_i),
        .csr_addr_i  (csr_addr_i),
        .csr_wdata_i (csr_wdata_i),
        .csr_imm_i   (csr_imm_i),
        .csr_rdata_o (csr_rdata_o),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .acc_valid_o (acc_valid),
        .acc_op_o    (acc_op),
        .acc_addr_o  (acc_addr),
        .acc_src_o   (acc_src),
        .acc_rdata_i (acc_rdata)
    );

    csr_file u_file (
        .clk             (clk),
        .rst_n           (rst_n),
        .acc_valid_i     (acc_valid),
        .acc_op_i        (acc_op),
        .acc_addr_i      (acc_addr),
        .acc_src_i       (acc_src),
        .acc_rdata_o     (acc_rdata),
        .instr_retired_i (instr_retired_i),
        .ext_irq_i       (ext_irq_i),
        .sw_irq_i        (sw_irq_i),
        .trap_enter_i    (trap_enter),
        .trap_cause_i    (trap_cause),
        .trap_epc_i      (trap_epc),
        .mret_exec_i     (mret_exec),
        .mstatus_mie_o   (mstatus_mie),
        .mie_o           (mie_q),
        .mtvec_o         (mtvec_q),
        .mepc_o          (mepc_q)
    );

    csr_trap_ctrl u_trap (
        .clk           (clk),
        .rst_n         (rst_n),
        .ext_irq_i     (ext_irq_i),
        .sw_irq_i      (sw_irq_i),
        .mret_i        (mret_i),
        .resume_pc_i   (resume_pc_i),
        .mstatus_mie_i (mstatus_mie),
        .mie_i         (mie_q),
        .mtvec_i       (mtvec_q),
        .mepc_i        (mepc_q),
        .trap_enter_o  (trap_enter),
        .trap_cause_o  (trap_cause),
        .trap_epc_o    (trap_epc),
        .mret_exec_o   (mret_exec),
        .trap_flush_o  (trap_flush_o),
        .trap_pc_o     (trap_pc_o)
    );

endmodule

//--- tests/tb_csr_subsystem.sv
`include "csr_cfg.svh"

module tb_csr_subsystem;
    timeunit 1ns;
    timeprecision 100ps;
    import csr_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 10;
    // Cycle budget of each test with room to spare.
    localparam int RMW_CYCLES   = 30;
    localparam int CNT_CYCLES   = 60;
    localparam int DBG_CYCLES   = 40;
    localparam int IRQ_CYCLES   = 20;
    localparam int VEC_CYCLES   = 30;
    localparam int RO_CYCLES    = 20;
    localparam int TOTAL_CYCLES = RST_CYCLES + RMW_CYCLES + CNT_CYCLES + DBG_CYCLES
                                  + IRQ_CYCLES + VEC_CYCLES + RO_CYCLES;
    localparam int ACK_LIMIT    = 16; // Cycles a Wishbone master waits for ack.

    logic                 clk;
    logic                 rst_n;
    logic                 csr_req_i;
    csr_op_e              csr_op_i;
    logic [11:0]          csr_addr_i;
    logic [`CSR_XLEN-1:0] csr_wdata_i;
    logic [4:0]           csr_imm_i;
    logic [`CSR_XLEN-1:0] csr_rdata_o;
    logic                 wb_cyc_i;
    logic                 wb_stb_i;
    logic                 wb_we_i;
    logic [11:0]          wb_adr_i;
    logic [`CSR_XLEN-1:0] wb_dat_i;
    logic [`CSR_XLEN-1:0] wb_dat_o;
    logic                 wb_ack_o;
    logic                 ext_irq_i;
    logic                 sw_irq_i;
    logic                 instr_retired_i;
    logic [`CSR_XLEN-1:0] resume_pc_i;
    logic                 mret_i;
    logic                 trap_flush_o;
    logic [`CSR_XLEN-1:0] trap_pc_o;

    integer      seed;
    int          errors;
    int          checks;
    string       test_name;
    logic [31:0] mscratch_model; // Last value written to mscratch.

    csr_subsystem dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests finished.");
        $display("Simulation FAILED");
        $finish;
    end

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s (%s): expected 0x%08h, actual 0x%08h",
                     test_name, what, expected, actual);
        end
    endtask

    // Advance to 2 ns after the next rising edge.
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) step();
    endtask

    // One core access. Returns the old value seen in the request cycle.
    task automatic csr_access(input csr_op_e op, input logic [11:0] addr,
                              input logic [31:0] operand, output logic [31:0] old);
        csr_req_i   = 1'b1;
        csr_op_i    = op;
        csr_addr_i  = addr;
        csr_wdata_i = operand;
        csr_imm_i   = operand[4:0];
        #1;
        old = csr_rdata_o;
        step();
        csr_req_i = 1'b0;
        csr_op_i  = CSR_NONE;
    endtask

    task automatic csr_read(input logic [11:0] addr, output logic [31:0] value);
        csr_access(CSR_NONE, addr, 32'd0, value);
    endtask

    task automatic csr_write(input logic [11:0] addr, input logic [31:0] value);
        logic [31:0] unused_old;
        csr_access(CSR_RW, addr, value, unused_old);
    endtask

    // Core keeps the port busy reading mscratch for n cycles.
    task automatic core_hold(input int n);
        for (int i = 0; i < n; i++) begin
            csr_req_i  = 1'b1;
            csr_op_i   = CSR_NONE;
            csr_addr_i = `CSR_ADDR_MSCRATCH;
            #1;
            check("core read under debug load", mscratch_model, csr_rdata_o);
            step();
        end
        csr_req_i = 1'b0;
    endtask

    // Wishbone classic transfer. Waits counts cycles from strobe to ack.
    task automatic wb_xfer(input logic we, input logic [11:0] addr, input logic [31:0] data,
                           output logic [31:0] rdata, output int waits);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = addr;
        wb_dat_i = data;
        waits    = 0;
        rdata    = '0;
        while (waits < ACK_LIMIT) begin
            step();
            waits++;
            if (wb_ack_o) break;
        end
        if (!wb_ack_o) begin
            errors++;
            $display("%s: no Wishbone ack within %0d cycles.", test_name, ACK_LIMIT);
        end
        rdata    = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    // Trap target from mtvec and the interrupt code.
    function automatic logic [31:0] tvec_target(input logic [31:0] mtvec, input int code);
        logic [31:0] base;
        base = mtvec & ~32'd3;
        if (mtvec[0]) begin
            return base + 32'(4 * code);
        end
        return base;
    endfunction

    task automatic test_rmw();
        csr_op_e     ops[6];
        logic [31:0] operand;
        logic [31:0] src;
        logic [31:0] old;
        test_name = "rmw_mscratch";
        ops = '{CSR_RW, CSR_RS, CSR_RC, CSR_RWI, CSR_RSI, CSR_RCI};
        for (int round = 0; round < 2; round++) begin
            for (int i = 0; i < 6; i++) begin
                operand = $random(seed);
                src = ops[i][2] ? {27'd0, operand[4:0]} : operand; // Immediate forms.
                csr_access(ops[i], `CSR_ADDR_MSCRATCH, operand, old);
                check("old value", mscratch_model, old);
                case (ops[i])
                    CSR_RW, CSR_RWI: mscratch_model = src;
                    CSR_RS, CSR_RSI: mscratch_model = mscratch_model | src;
                    default:         mscratch_model = mscratch_model & ~src;
                endcase
            end
        end
        csr_read(`CSR_ADDR_MSCRATCH, old);
        check("final value", mscratch_model, old);
    endtask

    task automatic test_counters();
        logic [31:0] v0;
        logic [31:0] v1;
        int          k;
        int          n;
        test_name = "counters";
        k = 3 + ($unsigned($random(seed)) % 6);
        n = 1 + ($unsigned($random(seed)) % 8);
        csr_read(`CSR_ADDR_MCYCLE, v0);
        wait_cycles(k - 1); // Second request lands k cycles later.
        csr_read(`CSR_ADDR_MCYCLE, v1);
        check("mcycle delta", 32'(k), v1 - v0);
        csr_read(`CSR_ADDR_CYCLE, v0);
        csr_read(`CSR_ADDR_MCYCLE, v1);
        check("cycle vs mcycle", v0 + 32'd1, v1);
        csr_read(`CSR_ADDR_MINSTRET, v0);
        repeat (n) begin
            instr_retired_i = 1'b1;
            step();
            instr_retired_i = 1'b0;
            step();
        end
        csr_read(`CSR_ADDR_MINSTRET, v1);
        check("minstret delta", 32'(n), v1 - v0);
        csr_read(`CSR_ADDR_INSTRET, v0);
        check("instret vs minstret", v1, v0);
    endtask

    task automatic test_debug();
        logic [31:0] data;
        logic [31:0] rd;
        int          waits;
        test_name = "debug_port";
        data = $random(seed);
        wb_xfer(1'b1, `CSR_ADDR_MTVEC, data, rd, waits);
        check("write ack latency", 32'd1, 32'(waits));
        csr_read(`CSR_ADDR_MTVEC, rd);
        check("core sees debug write", data, rd);
        check("ack is one cycle", 32'd0, 32'(wb_ack_o));
        wb_xfer(1'b0, `CSR_ADDR_MTVEC, 32'd0, rd, waits);
        check("read ack latency", 32'd1, 32'(waits));
        check("debug read data", data, rd);
        step();
        // Core holds the port for four cycles, so ack comes one cycle after.
        data = $random(seed);
        fork
            core_hold(4);
            wb_xfer(1'b1, `CSR_ADDR_MTVEC, data, rd, waits);
        join
        check("write ack under load", 32'd5, 32'(waits));
        step();
        fork
            core_hold(4);
            wb_xfer(1'b0, `CSR_ADDR_MTVEC, 32'd0, rd, waits);
        join
        check("read ack under load", 32'd5, 32'(waits));
        check("read data under load", data, rd);
    endtask

    task automatic test_irq_direct();
        logic [31:0] mtvec;
        logic [31:0] rd;
        test_name = "irq_direct";
        mtvec = 32'h8000_0102; // Low bits are not part of the base.
        resume_pc_i = 32'h0000_2468;
        csr_write(`CSR_ADDR_MTVEC, mtvec);
        csr_write(`CSR_ADDR_MIE, 32'd1 << `CSR_IRQ_MEI_BIT);
        csr_write(`CSR_ADDR_MSTATUS, 32'h0000_0008);
        ext_irq_i = 1'b1; // Detected in this cycle.
        step();
        check("flush after entry", 32'd1, 32'(trap_flush_o));
        check("trap target", tvec_target(mtvec, `CSR_IRQ_MEI_BIT), trap_pc_o);
        ext_irq_i = 1'b0;
        step();
        check("flush is one cycle", 32'd0, 32'(trap_flush_o));
        csr_read(`CSR_ADDR_MCAUSE, rd);
        check("mcause", 32'h8000_0000 | `CSR_IRQ_MEI_BIT, rd);
        csr_read(`CSR_ADDR_MEPC, rd);
        check("mepc", resume_pc_i, rd);
        csr_read(`CSR_ADDR_MSTATUS, rd);
        check("mstatus after entry", 32'h0000_0080, rd);
    endtask

    task automatic test_vectored_mret();
        logic [31:0] mtvec;
        logic [31:0] rd;
        test_name = "vectored_mret";
        mtvec = 32'h0000_4001;
        resume_pc_i = 32'h0000_3570;
        csr_write(`CSR_ADDR_MTVEC, mtvec);
        csr_write(`CSR_ADDR_MIE, 32'd1 << `CSR_IRQ_MEI_BIT);
        csr_write(`CSR_ADDR_MSTATUS, 32'h0000_0008);
        sw_irq_i = 1'b1; // Masked by mie.
        for (int i = 0; i < 4; i++) begin
            step();
            check("masked irq not taken", 32'd0, 32'(trap_flush_o));
        end
        csr_write(`CSR_ADDR_MIE, 32'd1 << `CSR_IRQ_MSI_BIT);
        step();
        check("flush after entry", 32'd1, 32'(trap_flush_o));
        check("vectored target", tvec_target(mtvec, `CSR_IRQ_MSI_BIT), trap_pc_o);
        sw_irq_i = 1'b0;
        step();
        csr_read(`CSR_ADDR_MCAUSE, rd);
        check("mcause", 32'h8000_0000 | `CSR_IRQ_MSI_BIT, rd);
        csr_read(`CSR_ADDR_MSTATUS, rd);
        check("mstatus after entry", 32'h0000_0080, rd);
        mret_i = 1'b1;
        step();
        mret_i = 1'b0;
        check("flush after mret", 32'd1, 32'(trap_flush_o));
        check("mret target", resume_pc_i, trap_pc_o);
        step();
        csr_read(`CSR_ADDR_MSTATUS, rd);
        check("mstatus after mret", 32'h0000_0088, rd);
    endtask

    task automatic test_read_only();
        logic [31:0] rd;
        test_name = "read_only";
        csr_write(`CSR_ADDR_MSTATUS, 32'd0); // Keep the lines below from trapping.
        csr_read(`CSR_ADDR_MISA, rd);
        check("misa", `CSR_MISA_VAL, rd);
        csr_write(`CSR_ADDR_MISA, 32'hFFFF_FFFF);
        csr_read(`CSR_ADDR_MISA, rd);
        check("misa after write", `CSR_MISA_VAL, rd);
        csr_write(12'h7C0, 32'hA5A5_A5A5);
        csr_read(12'h7C0, rd);
        check("unknown address", 32'd0, rd);
        ext_irq_i = 1'b1;
        sw_irq_i  = 1'b1;
        csr_read(`CSR_ADDR_MIP, rd);
        check("mip both lines", (32'd1 << `CSR_IRQ_MEI_BIT) | (32'd1 << `CSR_IRQ_MSI_BIT), rd);
        sw_irq_i = 1'b0;
        csr_read(`CSR_ADDR_MIP, rd);
        check("mip external only", 32'd1 << `CSR_IRQ_MEI_BIT, rd);
        ext_irq_i = 1'b0;
    endtask

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        csr_req_i       = 1'b0;
        csr_op_i        = CSR_NONE;
        csr_addr_i      = '0;
        csr_wdata_i     = '0;
        csr_imm_i       = '0;
        wb_cyc_i        = 1'b0;
        wb_stb_i        = 1'b0;
        wb_we_i         = 1'b0;
        wb_adr_i        = '0;
        wb_dat_i        = '0;
        ext_irq_i       = 1'b0;
        sw_irq_i        = 1'b0;
        instr_retired_i = 1'b0;
        resume_pc_i     = '0;
        mret_i          = 1'b0;
        seed            = 32'h1967_e5ac;
        errors          = 0;
        checks          = 0;
        mscratch_model  = '0;
        wait_cycles(RST_CYCLES);
        rst_n = 1'b1;
        test_name = "reset";
        check("wb_ack_o", 32'd0, 32'(wb_ack_o));
        check("trap_flush_o", 32'd0, 32'(trap_flush_o));
        check("trap_pc_o", 32'd0, trap_pc_o);
        test_rmw();
        test_counters();
        test_debug();
        test_irq_direct();
        test_vectored_mret();
        test_read_only();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+src
src/csr_pkg.sv
src/csr_file.sv
src/csr_port_arb.sv
src/csr_trap_ctrl.sv
src/csr_subsystem.sv
tests/tb_csr_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the CSR subsystem testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f sim.f \
    --top-module tb_csr_subsystem -Mdir obj_dir -o tb_csr_subsystem
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

output=$(./obj_dir/tb_csr_subsystem)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status."
    exit 1
fi

if echo "$output" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1
